/* duty_counter.sv */
// duty cycle sample counter, high and total counts latched per window
`timescale 1ns/10ps

module duty_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      measure_en,
    input  logic                      sample_valid,
    input  logic                      window_tick,
    input  signal_meter_pkg::sample_t sample_data,
    output signal_meter_pkg::count_t  high_count,
    output signal_meter_pkg::count_t  total_count,
    output logic                      count_strobe
);

    signal_meter_pkg::count_t high_cnt;
    signal_meter_pkg::count_t total_cnt;
    logic                     is_high;

    // above 127 is the same as at or above mid-scale
    assign is_high = sample_valid && (sample_data >= signal_meter_pkg::mid_scale);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            high_cnt     <= '0;
            total_cnt    <= '0;
            high_count   <= '0;
            total_count  <= '0;
            count_strobe <= 1'b0;
        end else if (!measure_en) begin
            high_cnt     <= '0;
            total_cnt    <= '0;
            high_count   <= '0;
            total_count  <= '0;
            count_strobe <= 1'b0;
        end else begin
            count_strobe <= window_tick;
            if (window_tick) begin
                // boundary sample closes out the current window
                high_count  <= high_cnt + signal_meter_pkg::count_t'(is_high);
                total_count <= total_cnt + signal_meter_pkg::count_t'(sample_valid);
                high_cnt    <= '0;
                total_cnt   <= '0;
            end else begin
                if (sample_valid) total_cnt <= total_cnt + 1'b1;
                if (is_high)      high_cnt  <= high_cnt + 1'b1;
            end
        end
    end

endmodule

/* duty_divider.sv */
// duty cycle divider, reciprocal table lookup and multiply in four stages
`timescale 1ns/10ps

module duty_divider (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      count_strobe,
    input  signal_meter_pkg::count_t  high_count,
    input  signal_meter_pkg::count_t  total_count,
    output signal_meter_pkg::result_t duty_value
);

    signal_meter_pkg::recip_t recip_table [0:255];
    signal_meter_pkg::count_t index_raw;
    logic [47:0]              numer_q;      // high times full scale
    logic [7:0]               index_q;
    signal_meter_pkg::recip_t recip_q;
    logic [63:0]              product_q;
    logic                     s1_valid, s2_valid, s3_valid;

    // constant Q16 reciprocal ROM
    for (genvar i = 0; i < 256; i++) begin : g_recip
        assign recip_table[i] = signal_meter_pkg::recip_of(8'(i));
    end

    assign index_raw = total_count >> signal_meter_pkg::duty_index_shift;

    // ====================
    // stage 1, numerator and index
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            numer_q  <= '0;
            index_q  <= 8'd1;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= count_strobe && (total_count != '0);  // empty window keeps old duty
            if (count_strobe && (total_count != '0)) begin
                numer_q <= 48'(high_count) * 48'(signal_meter_pkg::duty_scale);
                if (index_raw == '0)          index_q <= 8'd1;
                else if (index_raw > 32'd255) index_q <= 8'd255;
                else                          index_q <= index_raw[7:0];
            end
        end
    end

    // ====================
    // stages 2 to 4
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recip_q    <= '0;
            product_q  <= '0;
            duty_value <= '0;
            s2_valid   <= 1'b0;
            s3_valid   <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            if (s1_valid) recip_q   <= recip_table[index_q];   // lookup
            if (s2_valid) product_q <= numer_q * recip_q;      // multiply
            // drop the Q16 fraction and the index shift
            if (s3_valid) duty_value <= signal_meter_pkg::result_t'(
                              product_q >> (16 + signal_meter_pkg::duty_index_shift));
        end
    end

endmodule

/* freq_scaler.sv */
// crossing count to frequency scaler, Hz or kHz over a two-stage pipeline
`timescale 1ns/10ps

module freq_scaler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      count_strobe,
    input  signal_meter_pkg::count_t  crossing_count,
    output signal_meter_pkg::result_t freq_value,
    output logic                      freq_khz
);

    signal_meter_pkg::count_t count_q;
    logic                     khz_q;
    logic                     stage1_valid;
    logic [31:0]              hz_product;
    logic [47:0]              khz_product;

    assign hz_product  = count_q * signal_meter_pkg::hz_per_count;
    // divide by 100 as multiply by 655 then drop 16 bits
    assign khz_product = 48'(count_q) * 48'(signal_meter_pkg::khz_recip);

    // ====================
    // stage one, unit choice
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q      <= '0;
            khz_q        <= 1'b0;
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= count_strobe;
            if (count_strobe) begin
                count_q <= crossing_count;
                khz_q   <= (crossing_count > signal_meter_pkg::hz_limit);
            end
        end
    end

    // ====================
    // stage two, scaling
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            freq_value <= '0;
            freq_khz   <= 1'b0;
        end else if (stage1_valid) begin
            freq_khz   <= khz_q;
            freq_value <= khz_q ? khz_product[31:16] : hz_product[15:0];
        end
    end

endmodule

/* meas_window_timer.sv */
// measurement window timer, pulses once every window_cycles enabled clocks
`timescale 1ns/10ps

module meas_window_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic measure_en,
    output logic window_tick
);

    logic [signal_meter_pkg::window_cnt_w-1:0] cycle_cnt;
    logic                                      last_cycle;

    assign last_cycle = (cycle_cnt == signal_meter_pkg::window_cycles - 1);

    // tick on the window_cycles-th consecutive enabled cycle
    assign window_tick = measure_en && last_cycle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (!measure_en) begin
            cycle_cnt <= '0;          // restart window on disable
        end else if (last_cycle) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

/* peak_detector.sv */
// window peak-to-peak detector over valid samples
`timescale 1ns/10ps

module peak_detector (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      measure_en,
    input  logic                      sample_valid,
    input  logic                      window_tick,
    input  signal_meter_pkg::sample_t sample_data,
    output signal_meter_pkg::result_t amplitude
);

    signal_meter_pkg::sample_t max_q, min_q;
    signal_meter_pkg::sample_t max_next, min_next;  // includes current sample

    always_comb begin
        max_next = max_q;
        min_next = min_q;
        if (sample_valid) begin
            if (sample_data > max_q) max_next = sample_data;
            if (sample_data < min_q) min_next = sample_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            max_q     <= 8'd0;
            min_q     <= 8'd255;
            amplitude <= '0;
        end else if (!measure_en) begin
            max_q     <= 8'd0;
            min_q     <= 8'd255;
            amplitude <= '0;
        end else if (window_tick) begin
            // empty window leaves max below min, report zero then
            amplitude <= (max_next >= min_next) ?
                         signal_meter_pkg::result_t'(max_next - min_next) : '0;
            max_q     <= 8'd0;                    // reload for next window
            min_q     <= 8'd255;
        end else begin
            max_q <= max_next;
            min_q <= min_next;
        end
    end

endmodule

/* signal_meter.f */
signal_meter_pkg.sv
meas_window_timer.sv
zero_cross_counter.sv
freq_scaler.sv
peak_detector.sv
duty_counter.sv
duty_divider.sv
signal_meter_top.sv
signal_meter_sva.sv
signal_meter_tb.sv

/* signal_meter_pkg.sv */
// signal meter shared types, window constants and Q16 reciprocal helper
package signal_meter_pkg;

    // ====================
    // widths with a meaning
    // ====================
    typedef logic [7:0]  sample_t;   // one ADC sample
    typedef logic [31:0] count_t;    // per-window sample or crossing count
    typedef logic [15:0] result_t;   // Hz/kHz value, amplitude or duty
    typedef logic [15:0] recip_t;    // Q16 reciprocal

    // ====================
    // window and scaling
    // ====================
    // short window for simulation, stands for a 100 ms window
    localparam int unsigned window_cycles = 16384;
    localparam int unsigned window_cnt_w  = $clog2(window_cycles);

    localparam sample_t mid_scale = 8'd128;   // high when at or above

    // frequency scaling for a 100 ms window
    localparam int unsigned hz_per_count = 10;
    localparam count_t      hz_limit     = 32'd6553;  // above this Hz overflows
    localparam int unsigned khz_recip    = 655;        // 65536 / 100

    // duty in tenths of a percent
    localparam int unsigned duty_scale       = 1000;
    localparam int unsigned duty_index_shift = 7;  // total count to table index

    // 65536 / index, index 0 and 1 saturate to the largest Q16 value
    function automatic recip_t recip_of(input logic [7:0] index);
        logic [16:0] quotient;
        if (index <= 8'd1) begin
            quotient = 17'h0ffff;
        end else begin
            quotient = 17'h10000 / index;
        end
        return quotient[15:0];
    endfunction

endpackage

/* signal_meter_sva.sv */
// signal meter checks on the update strobe and the kHz output range
`timescale 1ns/10ps

module signal_meter_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      measure_en,
    input logic                      results_updated,
    input logic                      freq_is_khz,
    input signal_meter_pkg::result_t freq_out
);

    strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        results_updated |=> !results_updated)
        else $error("results_updated high for more than one cycle");

    // no update without an enabled window
    strobe_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        results_updated |-> measure_en)
        else $error("results_updated while measure_en low");

    khz_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        freq_is_khz |-> (freq_out < 16'd656))
        else $error("freq_out out of range in kHz mode");

endmodule

bind signal_meter_top signal_meter_sva sva_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .measure_en      (measure_en),
    .results_updated (results_updated),
    .freq_is_khz     (freq_is_khz),
    .freq_out        (freq_out)
);

/* signal_meter_tb.sv */
// testbench driving the signal meter with square waves from vectors and checking its outputs
`timescale 1ns/10ps

module signal_meter_tb;

    logic                      clk;
    logic                      rst_n;
    logic                      measure_en;
    logic                      sample_valid;
    signal_meter_pkg::sample_t sample_data;
    signal_meter_pkg::result_t freq_out;
    signal_meter_pkg::result_t amplitude_out;
    signal_meter_pkg::result_t duty_out;
    logic                      freq_is_khz;
    logic                      results_updated;

    // square wave of the running test
    int unsigned               wave_period;
    int unsigned               wave_high;     // high samples per period
    int unsigned               valid_every;
    signal_meter_pkg::sample_t low_level;
    signal_meter_pkg::sample_t high_level;
    int unsigned               phase_k;       // sample index since enable

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    signal_meter_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .measure_en      (measure_en),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .freq_out        (freq_out),
        .amplitude_out   (amplitude_out),
        .duty_out        (duty_out),
        .freq_is_khz     (freq_is_khz),
        .results_updated (results_updated)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // stimulus and checks
    // ====================
    // drive one sample at the rising edge and read back at the falling edge
    task automatic step_cycle(input logic enable);
        @(posedge clk);
        measure_en   <= enable;
        sample_data  <= ((phase_k % wave_period) >= (wave_period - wave_high)) ?
                        high_level : low_level;
        sample_valid <= ((phase_k % valid_every) == 0);
        phase_k++;
        @(negedge clk);
    endtask

    task automatic wait_update(output bit seen);
        int unsigned n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < signal_meter_pkg::window_cycles + 64) begin
            step_cycle(1'b1);
            seen = results_updated;
            n++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_test(input int num);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed with %0d mismatches", num, test_errors);
            tests_failed++;
        end
    endtask

    task automatic run_vector(input int f [10]);
        bit seen;
        test_errors = 0;
        repeat (2 + ($urandom % 8)) step_cycle(1'b0);  // idle cycles with enable low
        wave_period = f[1];
        wave_high   = f[2];
        low_level   = f[3];
        high_level  = f[4];
        valid_every = f[5];
        phase_k     = 0;
        // first update shows the partial pipeline and the second a full window
        wait_update(seen);
        if (seen) wait_update(seen);
        if (!seen) begin
            $display("test %0d: no results_updated pulse before the timeout", f[0]);
            timed_out = 1'b1;
            test_errors++;
        end else begin
            check_value("freq_out", freq_out, f[6]);
            check_value("freq_is_khz", freq_is_khz, f[7]);
            check_value("amplitude_out", amplitude_out, f[8]);
            check_value("duty_out", duty_out, f[9]);
        end
        report_test(f[0]);
    endtask

    // outputs must hold and no strobe may appear while disabled
    task automatic run_disable(input int num, input int last [10]);
        bit pulsed;
        test_errors = 0;
        pulsed      = 1'b0;
        repeat (signal_meter_pkg::window_cycles + 256) begin
            step_cycle(1'b0);
            if (results_updated) pulsed = 1'b1;
        end
        if (pulsed) begin
            $display("test %0d: results_updated pulsed while measure_en was low", num);
            test_errors++;
        end
        check_value("freq_out", freq_out, last[6]);
        check_value("freq_is_khz", freq_is_khz, last[7]);
        check_value("amplitude_out", amplitude_out, last[8]);
        check_value("duty_out", duty_out, last[9]);
        report_test(num);
    endtask

    initial begin
        int    fd;
        int    f [10];
        int    last_vec [10];
        string line;
        rst_n        = 1'b0;
        measure_en   = 1'b0;
        sample_valid = 1'b0;
        sample_data  = '0;
        wave_period  = 2;
        wave_high    = 1;
        valid_every  = 1;
        low_level    = '0;
        high_level   = '0;
        phase_k      = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(32'h3b6b));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("signal_meter_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open signal_meter_vectors.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9]) == 10) begin
                    run_vector(f);
                    last_vec = f;
                end
            end
            $fclose(fd);
            if (tests_run == 0) begin
                $display("no test vectors were read");
                errors++;
            end else if (!timed_out) begin
                run_disable(last_vec[0] + 1, last_vec);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* signal_meter_top.sv */
// signal meter top, frequency, amplitude and duty channels with output bank
`timescale 1ns/10ps

module signal_meter_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      measure_en,
    input  logic                      sample_valid,
    input  signal_meter_pkg::sample_t sample_data,
    output signal_meter_pkg::result_t freq_out,
    output signal_meter_pkg::result_t amplitude_out,
    output signal_meter_pkg::result_t duty_out,
    output logic                      freq_is_khz,
    output logic                      results_updated
);

    logic                      window_tick;

    // frequency path
    signal_meter_pkg::count_t  crossing_count;
    logic                      freq_strobe;
    signal_meter_pkg::result_t freq_value;
    logic                      freq_khz;

    signal_meter_pkg::result_t amplitude;

    // duty path
    signal_meter_pkg::count_t  high_count;
    signal_meter_pkg::count_t  total_count;
    logic                      duty_strobe;
    signal_meter_pkg::result_t duty_value;

    // ====================
    // window timing
    // ====================
    meas_window_timer timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .measure_en  (measure_en),
        .window_tick (window_tick)
    );

    // ====================
    // measurement channels
    // ====================
    zero_cross_counter zero_cross_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .measure_en     (measure_en),
        .sample_valid   (sample_valid),
        .window_tick    (window_tick),
        .sample_data    (sample_data),
        .crossing_count (crossing_count),
        .count_strobe   (freq_strobe)
    );

    freq_scaler freq_scaler_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .count_strobe   (freq_strobe),
        .crossing_count (crossing_count),
        .freq_value     (freq_value),
        .freq_khz       (freq_khz)
    );

    peak_detector peak_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .measure_en   (measure_en),
        .sample_valid (sample_valid),
        .window_tick  (window_tick),
        .sample_data  (sample_data),
        .amplitude    (amplitude)
    );

    duty_counter duty_count_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .measure_en   (measure_en),
        .sample_valid (sample_valid),
        .window_tick  (window_tick),
        .sample_data  (sample_data),
        .high_count   (high_count),
        .total_count  (total_count),
        .count_strobe (duty_strobe)
    );

    duty_divider duty_div_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .count_strobe (duty_strobe),
        .high_count   (high_count),
        .total_count  (total_count),
        .duty_value   (duty_value)
    );

    // output bank, loads previous window results on each tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            freq_out        <= '0;
            freq_is_khz     <= 1'b0;
            amplitude_out   <= '0;
            duty_out        <= '0;
            results_updated <= 1'b0;
        end else begin
            results_updated <= window_tick;  // high while new values first show
            if (window_tick) begin
                freq_out      <= freq_value;
                freq_is_khz   <= freq_khz;
                amplitude_out <= amplitude;
                duty_out      <= duty_value;
            end
        end
    end

endmodule

/* signal_meter_vectors.txt */
# test period high_per_period low_level high_level valid_every
#   expected: freq khz_flag amplitude duty_tenths_percent
1 64 32 40 200 1 2560 0 160 500
2 2 1 0 255 1 81 1 255 500
3 64 16 128 128 1 0 0 0 1000
4 64 16 40 200 1 2560 0 160 250
5 64 16 40 200 2 2560 0 160 250
6 100 30 10 250 1 1640 0 240 299
7 10 5 100 160 3 16380 0 60 507
8 2 1 127 128 1 81 1 1 500

/* zero_cross_counter.sv */
// mid-scale rising crossing counter, latches one count per window
`timescale 1ns/10ps

module zero_cross_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       measure_en,
    input  logic                       sample_valid,
    input  logic                       window_tick,
    input  signal_meter_pkg::sample_t  sample_data,
    output signal_meter_pkg::count_t   crossing_count,
    output logic                       count_strobe
);

    signal_meter_pkg::sample_t prev_sample;  // last valid sample
    logic                      have_prev;    // prev_sample holds real data
    signal_meter_pkg::count_t  cross_cnt;
    logic                      crossing;

    // rising crossing needs a previous valid sample below mid-scale
    assign crossing = sample_valid && have_prev &&
                      (prev_sample < signal_meter_pkg::mid_scale) &&
                      (sample_data >= signal_meter_pkg::mid_scale);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_sample <= '0;
            have_prev   <= 1'b0;
        end else if (!measure_en) begin
            prev_sample <= '0;
            have_prev   <= 1'b0;
        end else if (sample_valid) begin
            prev_sample <= sample_data;
            have_prev   <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cross_cnt      <= '0;
            crossing_count <= '0;
            count_strobe   <= 1'b0;
        end else if (!measure_en) begin
            cross_cnt      <= '0;
            crossing_count <= '0;
            count_strobe   <= 1'b0;
        end else begin
            count_strobe <= window_tick;   // data and strobe show up together
            if (window_tick) begin
                // tick-cycle crossing belongs to the closing window
                crossing_count <= cross_cnt + signal_meter_pkg::count_t'(crossing);
                cross_cnt      <= '0;
            end else if (crossing) begin
                cross_cnt <= cross_cnt + 1'b1;
            end
        end
    end

endmodule
